/* compute_socket.f */
source/sock_pkg.sv
source/job_dispatch.sv
source/compute_core.sv
source/result_arb.sv
source/compute_socket.sv
verification/compute_socket_assert.sv
verification/compute_socket_tb.sv

/* Bender.yml */
package:
  name: compute_socket

sources:
  # package first, top level last
  - source/sock_pkg.sv
  - source/job_dispatch.sv
  - source/compute_core.sv
  - source/result_arb.sv
  - source/compute_socket.sv

  # testbench and bound assertions
  - target: test
    files:
      - verification/compute_socket_assert.sv
      - verification/compute_socket_tb.sv

/* verification/compute_socket_tb.sv */
// compute socket testbench
// reference model, write monitor, directed and random job tests, watchdog
module compute_socket_tb;

    localparam int PERIOD     = 40;
    localparam int NC         = sock_pkg::SOCKET_SIZE;
    localparam int RAND_STEPS = 300;
    localparam int TOTAL_JOBS = 40 + RAND_STEPS;

    logic                               clk;
    logic                               reset;
    logic                               job_valid;
    logic [sock_pkg::CORE_BITS-1:0]     job_core;
    sock_pkg::core_op_e                 job_op;
    logic [sock_pkg::XLEN-1:0]          job_operand;
    logic                               job_reject;
    logic                               cfg_wr;
    logic [sock_pkg::ADDR_WIDTH-1:0]    cfg_base;
    logic                               mem_wr_valid;
    logic [sock_pkg::ADDR_WIDTH-1:0]    mem_wr_addr;
    logic [sock_pkg::XLEN-1:0]          mem_wr_data;
    logic                               busy;

    // model of each core and of its expected writes
    logic [sock_pkg::XLEN-1:0]          model_acc [NC];
    logic [sock_pkg::XLEN-1:0]          exp_data [NC][$];
    logic [sock_pkg::ADDR_WIDTH-1:0]    exp_addr [NC][$];
    logic [sock_pkg::ADDR_WIDTH-1:0]    model_base;
    bit                                 model_busy [NC];
    int                                 issue_cyc [NC];
    sock_pkg::core_op_e                 last_op [NC];

    int cycle_cnt = 0;
    int write_cnt = 0;
    int check_cnt = 0;
    int error_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int assert_seen = 0;
    int test_err_start;
    int seed_val;

    compute_socket compute_socket_inst (
        .clk          (clk),
        .reset        (reset),
        .job_valid    (job_valid),
        .job_core     (job_core),
        .job_op       (job_op),
        .job_operand  (job_operand),
        .job_reject   (job_reject),
        .cfg_wr       (cfg_wr),
        .cfg_base     (cfg_base),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and checks

    // new accumulator after one job
    function automatic logic [sock_pkg::XLEN-1:0] ref_result(input sock_pkg::core_op_e op,
            input logic [sock_pkg::XLEN-1:0] acc, input logic [sock_pkg::XLEN-1:0] operand);
        case (op)
            sock_pkg::OP_LOAD: return operand;
            sock_pkg::OP_ADD:  return acc + operand;
            sock_pkg::OP_XOR:  return acc ^ operand;
            default:           return acc * operand;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        error_cnt++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // arbiter assertion failures since the last call
    task automatic collect_assert_fails();
        int fails;
        fails = compute_socket_inst.result_arb_inst.compute_socket_assert_inst.fail_cnt;
        if (fails != assert_seen) begin
            error_cnt += fails - assert_seen;
            $display("ERROR at %0t: %0d arbiter assertions failed", $time,
                     fails - assert_seen);
            assert_seen = fails;
        end
    endtask

    function automatic int outstanding();
        int n;
        n = 0;
        for (int c = 0; c < NC; c++) begin
            n += exp_data[c].size();
        end
        return n;
    endfunction

    // compares every memory write against the per-core queues
    always @(posedge clk) begin
        logic [sock_pkg::ADDR_WIDTH-1:0] offs;
        if (!reset && mem_wr_valid) begin
            write_cnt++;
            offs = mem_wr_addr - model_base;
            if (offs >= NC) begin
                report_error($sformatf("write to 0x%0h lies outside the core range",
                                       mem_wr_addr));
            end else if (exp_data[offs].size() == 0) begin
                report_error($sformatf("write from core %0d with no job outstanding", offs));
            end else begin
                check_value("mem_wr_addr", mem_wr_addr, exp_addr[offs].pop_front());
                check_value("mem_wr_data", mem_wr_data, exp_data[offs].pop_front());
                if (exp_data[offs].size() == 0) begin
                    model_busy[offs] = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // one job held for one cycle, then the reject answer is checked
    task automatic send_job(input int core, input sock_pkg::core_op_e op,
                            input logic [31:0] operand, input bit expect_reject);
        job_valid   = 1'b1;
        job_core    = sock_pkg::CORE_BITS'(core);
        job_op      = op;
        job_operand = operand;
        if (!expect_reject) begin
            model_acc[core] = ref_result(op, model_acc[core], operand);
            exp_data[core].push_back(model_acc[core]);
            exp_addr[core].push_back(model_base + sock_pkg::ADDR_WIDTH'(core));
            model_busy[core] = 1'b1;
            issue_cyc[core]  = cycle_cnt;
            last_op[core]    = op;
        end
        @(negedge clk);
        job_valid = 1'b0;
        check_value("job_reject", job_reject, expect_reject);
        // an accepted job makes the socket busy right away
        if (!expect_reject) begin
            check_value("busy", busy, 1'b1);
        end
    endtask

    task automatic wait_quiet();
        while (busy || outstanding() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        collect_assert_fails();
        tests_run++;
        if (error_cnt == test_err_start) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name,
                     error_cnt - test_err_start);
        end
        test_err_start = error_cnt;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        int                      core;
        int                      since;
        int                      writes_before;
        sock_pkg::core_op_e      op;
        logic [31:0]             operand;
        seed_val    = $urandom(96867);
        reset       = 1'b1;
        job_valid   = 1'b0;
        job_core    = '0;
        job_op      = sock_pkg::OP_LOAD;
        job_operand = '0;
        cfg_wr      = 1'b0;
        cfg_base    = '0;
        model_base  = '0;
        for (int c = 0; c < NC; c++) begin
            model_acc[c]  = '0;
            model_busy[c] = 1'b0;
            issue_cyc[c]  = 0;
            last_op[c]    = sock_pkg::OP_LOAD;
        end
        test_err_start = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // quiet after reset, then one load per core
        repeat (3) @(negedge clk);
        check_value("busy", busy, 1'b0);
        check_value("write count", write_cnt, 0);
        for (int c = 0; c < NC; c++) begin
            send_job(c, sock_pkg::OP_LOAD, $urandom(), 1'b0);
        end
        wait_quiet();
        check_value("write count", write_cnt, NC);
        end_test("load per core");

        // chained ops on core 2
        send_job(2, sock_pkg::OP_ADD, $urandom(), 1'b0);
        wait_quiet();
        send_job(2, sock_pkg::OP_XOR, $urandom(), 1'b0);
        wait_quiet();
        send_job(2, sock_pkg::OP_MUL, $urandom(), 1'b0);
        wait_quiet();
        send_job(2, sock_pkg::OP_ADD, $urandom(), 1'b0);
        wait_quiet();
        send_job(2, sock_pkg::OP_MUL, $urandom(), 1'b0);
        wait_quiet();
        end_test("op chain");

        // new base moves every later write
        cfg_wr     = 1'b1;
        cfg_base   = 16'h2a40;
        model_base = 16'h2a40;
        @(negedge clk);
        cfg_wr = 1'b0;
        for (int c = 0; c < NC; c++) begin
            send_job(c, sock_pkg::OP_XOR, $urandom(), 1'b0);
        end
        wait_quiet();
        end_test("base address");

        // two multiplies and two loads that finish on top of each other
        writes_before = write_cnt;
        send_job(0, sock_pkg::OP_MUL, $urandom(), 1'b0);
        send_job(1, sock_pkg::OP_MUL, $urandom(), 1'b0);
        repeat (6) @(negedge clk);
        send_job(2, sock_pkg::OP_LOAD, $urandom(), 1'b0);
        send_job(3, sock_pkg::OP_LOAD, $urandom(), 1'b0);
        wait_quiet();
        check_value("write count", write_cnt - writes_before, NC);
        end_test("simultaneous finish");

        // jobs to a core in the middle of a multiply are dropped
        send_job(3, sock_pkg::OP_MUL, $urandom(), 1'b0);
        send_job(3, sock_pkg::OP_ADD, $urandom(), 1'b1);
        repeat (3) @(negedge clk);
        send_job(3, sock_pkg::OP_XOR, $urandom(), 1'b1);
        wait_quiet();
        send_job(3, sock_pkg::OP_ADD, $urandom(), 1'b0);
        wait_quiet();
        end_test("busy reject");

        // random traffic, rejects only where the core is surely busy
        for (int s = 0; s < RAND_STEPS; s++) begin
            core    = $urandom_range(0, NC - 1);
            op      = sock_pkg::core_op_e'($urandom_range(0, 3));
            operand = $urandom();
            since   = cycle_cnt - issue_cyc[core];
            if (!model_busy[core]) begin
                send_job(core, op, operand, 1'b0);
            end else if (since == 1 ||
                         (last_op[core] == sock_pkg::OP_MUL && since <= sock_pkg::MUL_CYCLES)) begin
                send_job(core, op, operand, 1'b1);
            end else begin
                @(negedge clk);
            end
        end
        wait_quiet();
        check_value("busy", busy, 1'b0);
        end_test("random jobs");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog, scaled to the worst case per job
    initial begin
        #((TOTAL_JOBS * (sock_pkg::MUL_CYCLES + 8) + 200) * PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* verification/compute_socket_assert.sv */
// result arbiter assertions
// grant encoding, grant against request, write strobe timing
module compute_socket_assert (
    input logic                                 clk,
    input logic                                 reset,
    input logic [sock_pkg::SOCKET_SIZE-1:0]     core_req,
    input logic [sock_pkg::SOCKET_SIZE-1:0]     core_grant,
    input logic                                 mem_wr_valid
);

    // number of failed assertions so far
    int fail_cnt = 0;

    // at most one winner per cycle
    grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(core_grant)
    ) else begin
        fail_cnt++;
        $error("grant is not one-hot or zero");
    end

    // no grant to a core that is not asking
    grant_has_req: assert property (
        @(posedge clk) disable iff (reset)
        (core_grant & ~core_req) == '0
    ) else begin
        fail_cnt++;
        $error("grant given to a core without a request");
    end

    // registered write one cycle after each grant
    write_after_grant: assert property (
        @(posedge clk) disable iff (reset)
        mem_wr_valid == $past(|core_grant)
    ) else begin
        fail_cnt++;
        $error("memory write does not follow a grant by one cycle");
    end

endmodule

bind result_arb compute_socket_assert compute_socket_assert_inst (
    .clk          (clk),
    .reset        (reset),
    .core_req     (core_req),
    .core_grant   (core_grant),
    .mem_wr_valid (mem_wr_valid)
);

/* source/compute_socket.sv */
// compute socket top
// dispatcher, generated cores and result arbiter
module compute_socket (
    input  logic                                clk,
    input  logic                                reset,

    // job input
    input  logic                                job_valid,
    input  logic [sock_pkg::CORE_BITS-1:0]      job_core,
    input  sock_pkg::core_op_e                  job_op,
    input  logic [sock_pkg::XLEN-1:0]           job_operand,
    output logic                                job_reject,

    // base address config
    input  logic                                cfg_wr,
    input  logic [sock_pkg::ADDR_WIDTH-1:0]     cfg_base,

    // memory write port
    output logic                                mem_wr_valid,
    output logic [sock_pkg::ADDR_WIDTH-1:0]     mem_wr_addr,
    output logic [sock_pkg::XLEN-1:0]           mem_wr_data,

    output logic                                busy
);

    logic [sock_pkg::SOCKET_SIZE-1:0]   core_start;
    logic [sock_pkg::SOCKET_SIZE-1:0]   core_idle;
    logic [sock_pkg::SOCKET_SIZE-1:0]   core_req;
    logic [sock_pkg::SOCKET_SIZE-1:0]   core_grant;
    logic [sock_pkg::XLEN-1:0]          core_result [sock_pkg::SOCKET_SIZE];
    sock_pkg::core_op_e                 core_op;
    logic [sock_pkg::XLEN-1:0]          core_operand;

    job_dispatch job_dispatch_inst (
        .clk          (clk),
        .reset        (reset),
        .job_valid    (job_valid),
        .job_core     (job_core),
        .job_op       (job_op),
        .job_operand  (job_operand),
        .core_idle    (core_idle),
        .core_start   (core_start),
        .core_op      (core_op),
        .core_operand (core_operand),
        .job_reject   (job_reject)
    );

    //////////////////////////////////////////////////////////////////////
    // cores

    for (genvar i = 0; i < sock_pkg::SOCKET_SIZE; i++) begin : g_core
        compute_core compute_core_inst (
            .clk     (clk),
            .reset   (reset),
            .start   (core_start[i]),
            .op      (core_op),
            .operand (core_operand),
            .grant   (core_grant[i]),
            .req     (core_req[i]),
            .result  (core_result[i]),
            .idle    (core_idle[i])
        );
    end

    result_arb result_arb_inst (
        .clk          (clk),
        .reset        (reset),
        .cfg_wr       (cfg_wr),
        .cfg_base     (cfg_base),
        .core_req     (core_req),
        .core_result  (core_result),
        .core_grant   (core_grant),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data)
    );

    // any core still working or waiting for its grant
    assign busy = |(~core_idle);

endmodule

/* source/result_arb.sv */
// round-robin result arbiter
// drains core results onto the memory write port at base + core index
module result_arb (
    input  logic                                clk,
    input  logic                                reset,

    // base address config
    input  logic                                cfg_wr,
    input  logic [sock_pkg::ADDR_WIDTH-1:0]     cfg_base,

    // core side
    input  logic [sock_pkg::SOCKET_SIZE-1:0]    core_req,
    input  logic [sock_pkg::XLEN-1:0]           core_result [sock_pkg::SOCKET_SIZE],
    output logic [sock_pkg::SOCKET_SIZE-1:0]    core_grant,

    // memory write port
    output logic                                mem_wr_valid,
    output logic [sock_pkg::ADDR_WIDTH-1:0]     mem_wr_addr,
    output logic [sock_pkg::XLEN-1:0]           mem_wr_data
);

    logic [sock_pkg::CORE_BITS-1:0]     rr_ptr;
    logic [sock_pkg::CORE_BITS-1:0]     cand;
    logic [sock_pkg::CORE_BITS-1:0]     win_idx;
    logic                               win_found;
    logic [sock_pkg::ADDR_WIDTH-1:0]    base_q;

    //////////////////////////////////////////////////////////////////////
    // winner select

    // search starts at the pointer and wraps around
    always_comb begin
        core_grant = '0;
        win_idx    = '0;
        win_found  = 1'b0;
        cand       = '0;
        for (int i = 0; i < sock_pkg::SOCKET_SIZE; i++) begin
            cand = rr_ptr + i[sock_pkg::CORE_BITS-1:0];
            if (!win_found && core_req[cand]) begin
                core_grant[cand] = 1'b1;
                win_idx          = cand;
                win_found        = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointer, base and write strobe

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr       <= '0;
            base_q       <= '0;
            mem_wr_valid <= 1'b0;
        end else begin
            // next search begins just past the winner
            if (win_found) begin
                rr_ptr <= win_idx + 1'b1;
            end
            if (cfg_wr) begin
                base_q <= cfg_base;
            end
            mem_wr_valid <= win_found;
        end
    end

    // write payload, taken from the granted core
    always_ff @(posedge clk) begin
        if (win_found) begin
            mem_wr_addr <= base_q
                         + {{(sock_pkg::ADDR_WIDTH - sock_pkg::CORE_BITS){1'b0}}, win_idx};
            mem_wr_data <= core_result[win_idx];
        end
    end

endmodule

/* source/compute_core.sv */
// compute core with one accumulator
// executes load/add/xor in one cycle, shift-add multiply over several
module compute_core (
    input  logic                        clk,
    input  logic                        reset,

    // from dispatcher
    input  logic                        start,
    input  sock_pkg::core_op_e          op,
    input  logic [sock_pkg::XLEN-1:0]   operand,

    // result handshake with arbiter
    input  logic                        grant,
    output logic                        req,
    output logic [sock_pkg::XLEN-1:0]   result,

    output logic                        idle
);

    sock_pkg::core_state_e state;

    logic [sock_pkg::XLEN-1:0]          acc;
    logic [sock_pkg::MUL_CNT_BITS-1:0]  mul_cnt;
    logic                               mul_last;

    // multiply datapath
    logic [sock_pkg::XLEN-1:0]          mcand;
    logic [sock_pkg::XLEN-1:0]          mplier;
    logic [sock_pkg::XLEN-1:0]          prod;
    logic [sock_pkg::XLEN-1:0]          partial;
    logic [sock_pkg::XLEN-1:0]          step_sum;

    //////////////////////////////////////////////////////////////////////
    // shift-add step

    // partial product of the multiplicand and the low digit of the multiplier
    always_comb begin
        partial = '0;
        for (int b = 0; b < sock_pkg::MUL_STEP; b++) begin
            if (mplier[b]) begin
                partial = partial + (mcand << b);
            end
        end
    end

    assign step_sum = prod + partial;
    assign mul_last = (int'(mul_cnt) == sock_pkg::MUL_CYCLES - 1);

    //////////////////////////////////////////////////////////////////////
    // core FSM and accumulator

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= sock_pkg::ST_IDLE;
            acc     <= '0;
            mul_cnt <= '0;
        end else begin
            case (state)
                sock_pkg::ST_IDLE: begin
                    if (start) begin
                        mul_cnt <= '0;
                        case (op)
                            sock_pkg::OP_LOAD: begin
                                acc   <= operand;
                                state <= sock_pkg::ST_HOLD;
                            end
                            sock_pkg::OP_ADD: begin
                                acc   <= acc + operand;
                                state <= sock_pkg::ST_HOLD;
                            end
                            sock_pkg::OP_XOR: begin
                                acc   <= acc ^ operand;
                                state <= sock_pkg::ST_HOLD;
                            end
                            default: begin
                                state <= sock_pkg::ST_EXEC;
                            end
                        endcase
                    end
                end
                sock_pkg::ST_EXEC: begin
                    mul_cnt <= mul_cnt + 1'b1;
                    // low XLEN bits of the product become the accumulator
                    if (mul_last) begin
                        acc   <= step_sum;
                        state <= sock_pkg::ST_HOLD;
                    end
                end
                sock_pkg::ST_HOLD: begin
                    if (grant) begin
                        state <= sock_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= sock_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // multiply operands, loaded on every start
    always_ff @(posedge clk) begin
        if (state == sock_pkg::ST_IDLE && start) begin
            mcand  <= acc;
            mplier <= operand;
            prod   <= '0;
        end else if (state == sock_pkg::ST_EXEC) begin
            mcand  <= mcand << sock_pkg::MUL_STEP;
            mplier <= mplier >> sock_pkg::MUL_STEP;
            prod   <= step_sum;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs

    // request held until granted, result is the accumulator itself
    assign req    = (state == sock_pkg::ST_HOLD);
    assign result = acc;

    // busy from the start pulse on, free again in the grant cycle
    assign idle = ((state == sock_pkg::ST_IDLE) && !start)
                | ((state == sock_pkg::ST_HOLD) && grant);

endmodule

/* source/job_dispatch.sv */
// job dispatcher
// registers incoming jobs and steers them to an idle core or rejects them
module job_dispatch (
    input  logic                                clk,
    input  logic                                reset,

    // job strobe from outside
    input  logic                                job_valid,
    input  logic [sock_pkg::CORE_BITS-1:0]      job_core,
    input  sock_pkg::core_op_e                  job_op,
    input  logic [sock_pkg::XLEN-1:0]           job_operand,

    // per core status
    input  logic [sock_pkg::SOCKET_SIZE-1:0]    core_idle,

    // to cores
    output logic [sock_pkg::SOCKET_SIZE-1:0]    core_start,
    output sock_pkg::core_op_e                  core_op,
    output logic [sock_pkg::XLEN-1:0]           core_operand,

    output logic                                job_reject
);

    logic target_idle;
    logic job_accept;

    // only place where idle is looked at
    assign target_idle = core_idle[job_core];
    assign job_accept  = job_valid & target_idle;

    //////////////////////////////////////////////////////////////////////
    // start decode and reject

    always_ff @(posedge clk) begin
        if (reset) begin
            core_start <= '0;
            job_reject <= 1'b0;
        end else begin
            core_start <= '0;
            // one-hot start for the target core
            if (job_accept) begin
                core_start[job_core] <= 1'b1;
            end
            // busy target drops the job
            job_reject <= job_valid & ~target_idle;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shared job payload

    // cores capture this on their start pulse
    always_ff @(posedge clk) begin
        if (job_accept) begin
            core_op      <= job_op;
            core_operand <= job_operand;
        end
    end

endmodule

/* source/sock_pkg.sv */
// socket sizing, data widths and multiply timing
// opcode and core state enums
package sock_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizing

    // number of cores in the socket
    localparam int SOCKET_SIZE = 4;
    localparam int CORE_BITS   = $clog2(SOCKET_SIZE);

    // datapath and memory port widths
    localparam int XLEN       = 32;
    localparam int ADDR_WIDTH = 16;

    //////////////////////////////////////////////////////////////////////
    // multiply

    // iterations per multiply, each one consumes MUL_STEP operand bits
    localparam int MUL_CYCLES   = 8;
    localparam int MUL_STEP     = XLEN / MUL_CYCLES;
    localparam int MUL_CNT_BITS = $clog2(MUL_CYCLES);

    //////////////////////////////////////////////////////////////////////
    // encodings

    // job opcodes
    typedef enum logic [1:0] {
        OP_LOAD,
        OP_ADD,
        OP_XOR,
        OP_MUL
    } core_op_e;

    // core FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_HOLD
    } core_state_e;

endpackage
